/* dv/hscale_properties.sv */
`default_nettype none
`timescale 1ns/1ps

module hscale_properties (
   input logic clk,
   input logic rst_n,
   input logic pix_valid,
   input logic bvalid,
   input logic bready,
   input logic rvalid,
   input logic rready,
   input logic [31:0] rdata,
   input logic gnt0,
   input logic gnt1
);

   // The filter adder trees need three idle cycles between pixels
   a_pix_spacing: assert property (@(posedge clk) disable iff (!rst_n)
      pix_valid |-> !$past(pix_valid, 1) && !$past(pix_valid, 2) && !$past(pix_valid, 3))
      else $error("Pixel strobes arrived closer than four cycles apart");

   a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid)
      else $error("Write response dropped before bready");

   a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else $error("Read response changed or dropped before rready");

   a_gnt_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(gnt0 && gnt1))
      else $error("Both memory ports granted in one cycle");

endmodule

bind hscale_top hscale_properties u_props (
   .clk(clk), .rst_n(rst_n), .pix_valid(pix_valid),
   .bvalid(bvalid), .bready(bready),
   .rvalid(rvalid), .rready(rready), .rdata(rdata),
   .gnt0(u_pk_port.gnt), .gnt1(u_host_port.gnt)
);

`default_nettype wire

/* dv/hscale_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module hscale_tb;
   import hscale_pkg::*;

   localparam int MEM_WORDS = 64;
   // Four passes of up to 300 pixels at up to 7 cycles each, plus the readback
   localparam int MAX_CYCLES = 20000;

   logic clk = 1'b0;
   logic rst_n;
   logic pix_valid;
   logic [PIX_W-1:0] pix_data;
   logic [AXI_ADDR_W-1:0] awaddr;
   logic [AXI_ADDR_W-1:0] araddr;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [WORD_W-1:0] wdata;
   logic [WORD_W-1:0] rdata;
   logic [3:0] wstrb;
   logic [1:0] bresp;
   logic [1:0] rresp;

   logic [31:0] rng;
   logic [31:0] rng_rd;
   int cycles = 0;
   int err_count = 0;

   // Reference model state, hist[k] is the sample k steps back
   logic [PIX_W-1:0] hist [9];
   logic [WORD_W-1:0] cur;
   logic [WORD_W-1:0] exp_mem [MEM_WORDS];
   int n_sample;
   int lane;
   int words;
   int factor;

   hscale_top #(.MEM_WORDS(MEM_WORDS)) u_dut (.*);

   always #10 clk = ~clk;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
         fail_run("Timeout: the run did not finish within the cycle limit");
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         err_count++;
         fail_run($sformatf("** Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                            $time, name, got, exp));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   task automatic model_clear();
      for (int i = 0; i < 9; i++)
         hist[i] = '0;
      n_sample = 0;
      lane = 0;
      words = 0;
   endtask

   task automatic model_push(input logic [PIX_W-1:0] x);
      int s2;
      int s4;
      logic [PIX_W-1:0] out;
      for (int i = 8; i > 0; i--)
         hist[i] = hist[i-1];
      hist[0] = x;
      // Both kernels start two samples back
      s2 = hist[2] + 2 * hist[3] + hist[4];
      s4 = hist[2] + 2 * hist[3] + 3 * hist[4] + 4 * hist[5]
           + 3 * hist[6] + 2 * hist[7] + hist[8];
      case (factor)
         2: out = 8'(s2 / 4);
         4: out = 8'(s4 / 16);
         default: out = x;
      endcase
      if ((n_sample % factor == factor - 1) && (words < MEM_WORDS))
      begin
         cur[8*lane +: 8] = out;
         lane++;
         if (lane == 4)
         begin
            exp_mem[words] = cur;
            words++;
            lane = 0;
         end
      end
      n_sample++;
   endtask

   // All stimulus tasks start and end on a falling edge
   task automatic send_pixel(input logic [PIX_W-1:0] x, input int idle);
      pix_valid = 1'b1;
      pix_data = x;
      @(negedge clk);
      pix_valid = 1'b0;
      repeat (idle) @(negedge clk);
   endtask

   task automatic stream(input int npix);
      for (int i = 0; i < npix; i++)
      begin
         rng = xorshift32(rng);
         model_push(rng[7:0]);
         send_pixel(rng[7:0], 3 + int'(rng[17:16]));
      end
   endtask

   task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
      awaddr = addr;
      awvalid = 1'b1;
      wdata = data;
      wvalid = 1'b1;
      wstrb = 4'hf;
      while (!(awready && wready))
         @(negedge clk);
      @(negedge clk);
      awvalid = 1'b0;
      wvalid = 1'b0;
      while (!bvalid)
         @(negedge clk);
      check_val("bresp", bresp, 0);
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
      check_val("bvalid", bvalid, 0);
      if (addr == ADDR_CTRL)
      begin
         case (data[1:0])
            SCALE_2X: factor = 2;
            SCALE_4X: factor = 4;
            default: factor = 1;
         endcase
         model_clear();
      end
   endtask

   // hold is the number of cycles rready stays low once rvalid is seen
   task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input int hold,
                           output logic [WORD_W-1:0] data);
      araddr = addr;
      arvalid = 1'b1;
      rready = (hold == 0);
      while (!arready)
         @(negedge clk);
      @(negedge clk);
      arvalid = 1'b0;
      while (!rvalid)
         @(negedge clk);
      data = rdata;
      check_val("rresp", rresp, 0);
      for (int i = 0; i < hold; i++)
      begin
         @(negedge clk);
         check_val("rvalid", rvalid, 1);
         check_val("rdata", rdata, data);
      end
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
      check_val("rvalid", rvalid, 0);
   endtask

   task automatic wait_status(input int exp);
      logic [WORD_W-1:0] v;
      for (int t = 0; t < 20; t++)
      begin
         axi_read(ADDR_STATUS, 0, v);
         if (v == exp)
            break;
      end
      check_val("status", v, exp);
   endtask

   task automatic check_words(input int first, input int count);
      logic [WORD_W-1:0] v;
      for (int i = first; i < first + count; i++)
      begin
         axi_read(ADDR_MEM_BASE + AXI_ADDR_W'(4 * i), 0, v);
         check_val($sformatf("word[%0d]", i), v, exp_mem[i]);
      end
   endtask

   task automatic run_pass(input logic [1:0] code, input int npix, input int nwords);
      axi_write(ADDR_CTRL, WORD_W'(code));
      stream(npix);
      wait_status(nwords);
      check_words(0, nwords);
   endtask

   task automatic random_reads(input int nreads);
      logic [WORD_W-1:0] v;
      int idx;
      for (int r = 0; r < nreads; r++)
      begin
         rng_rd = xorshift32(rng_rd);
         // Words from 8 up are left alone by the short 4x stream
         idx = 8 + int'(rng_rd[15:0] % 16'd56);
         axi_read(ADDR_MEM_BASE + AXI_ADDR_W'(4 * idx), int'(rng_rd[18:16]), v);
         check_val($sformatf("word[%0d]", idx), v, exp_mem[idx]);
      end
   endtask

   initial
   begin
      logic [WORD_W-1:0] v;
      rng = 32'd7;
      rst_n = 1'b0;
      pix_valid = 1'b0;
      pix_data = '0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      factor = 1;
      model_clear();
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      check_val("bvalid", bvalid, 0);
      check_val("rvalid", rvalid, 0);
      check_val("awready", awready, 1);
      check_val("wready", wready, 1);
      check_val("arready", arready, 1);
      axi_read(ADDR_STATUS, 0, v);
      check_val("status", v, 0);
      axi_read(ADDR_CTRL, 0, v);
      check_val("ctrl", v, 0);

      run_pass(SCALE_1X, 64, 16);
      run_pass(SCALE_2X, 96, 12);
      run_pass(SCALE_4X, 160, 10);

      // Saturation, word 63 ends up holding pixels 252 to 255
      run_pass(SCALE_1X, 300, MEM_WORDS);
      axi_write(ADDR_CTRL, WORD_W'(SCALE_1X));
      axi_read(ADDR_STATUS, 0, v);
      check_val("status", v, 0);

      // Host reads with back-pressure while the packer writes
      axi_write(ADDR_CTRL, WORD_W'(SCALE_4X));
      rng_rd = xorshift32(rng);
      fork
         stream(64);
         random_reads(24);
      join
      wait_status(4);
      check_words(0, MEM_WORDS);

      if (err_count == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/host_axil_slave.sv */
`default_nettype none
`timescale 1ns/1ps

module host_axil_slave #(
   parameter int MEM_WORDS = 64
) (
   input logic clk,
   input logic rst_n,
   input logic [hscale_pkg::AXI_ADDR_W-1:0] awaddr,
   input logic awvalid,
   output logic awready,
   input logic [hscale_pkg::WORD_W-1:0] wdata,
   input logic [3:0] wstrb,
   input logic wvalid,
   output logic wready,
   output logic [1:0] bresp,
   output logic bvalid,
   input logic bready,
   input logic [hscale_pkg::AXI_ADDR_W-1:0] araddr,
   input logic arvalid,
   output logic arready,
   output logic [hscale_pkg::WORD_W-1:0] rdata,
   output logic [1:0] rresp,
   output logic rvalid,
   input logic rready,
   input logic [$clog2(MEM_WORDS):0] words_written,
   output logic [1:0] scale,
   output logic clear,
   mem_port_if.requester mem
);
   import hscale_pkg::*;

   localparam int AW = $clog2(MEM_WORDS);

   logic wr_fire;
   logic ctrl_wr;
   logic ar_fire;
   logic mem_rd;
   logic mem_fresh;
   logic [WORD_W-1:0] reg_rdata;
   logic [WORD_W-1:0] rdata_q;

   // Address and data are taken only together, never one channel alone
   assign awready = !bvalid && (wvalid || !awvalid);
   assign wready = !bvalid && (awvalid || !wvalid);
   assign wr_fire = awvalid && wvalid && !bvalid;
   assign ctrl_wr = (awaddr == ADDR_CTRL);
   assign bresp = 2'b00;
   assign rresp = 2'b00;

   assign arready = !(mem.req || rvalid);
   assign ar_fire = arvalid && arready;
   assign mem_rd = (araddr >= ADDR_MEM_BASE)
                   && (int'(araddr) < int'(ADDR_MEM_BASE) + 4 * MEM_WORDS);

   always_comb
   begin
      case (araddr)
         ADDR_CTRL: reg_rdata = WORD_W'(scale);
         ADDR_STATUS: reg_rdata = WORD_W'(words_written);
         default: reg_rdata = '0;
      endcase
   end

   // RAM data is only valid in the cycle after gnt, later it comes from the hold register
   assign rdata = mem_fresh ? mem.rdata.word : rdata_q;

   assign mem.we = 1'b0;
   assign mem.wdata = '0;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         bvalid <= 1'b0;
         clear <= 1'b0;
         scale <= SCALE_1X;
      end
      else
      begin
         clear <= wr_fire && ctrl_wr;
         if (wr_fire)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         if (wr_fire && ctrl_wr && wstrb[0])
            scale <= wdata[1:0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rvalid <= 1'b0;
         mem.req <= 1'b0;
         mem_fresh <= 1'b0;
      end
      else
      begin
         mem_fresh <= mem.gnt;
         if (ar_fire && mem_rd)
            mem.req <= 1'b1;
         else if (mem.gnt)
            mem.req <= 1'b0;
         if ((ar_fire && !mem_rd) || mem.gnt)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (ar_fire)
      begin
         rdata_q <= reg_rdata;
         mem.addr <= AW'((araddr - ADDR_MEM_BASE) >> 2);
      end
      else if (mem_fresh)
         rdata_q <= mem.rdata.word;
   end

endmodule

`default_nettype wire

/* hdl/hscale_h_filter.sv */
`default_nettype none
`timescale 1ns/1ps

module hscale_h_filter (
   input logic clk,
   input logic rst_n,
   input logic clear,
   input logic pix_valid,
   input logic [hscale_pkg::PIX_W-1:0] pix_data,
   output logic out_valid,
   output logic [hscale_pkg::PIX_W-1:0] o1,
   output logic [hscale_pkg::PIX_W-1:0] o2,
   output logic [hscale_pkg::PIX_W-1:0] o4
);
   import hscale_pkg::*;

   logic [PIX_W-1:0] tap2 [3];
   logic [PIX_W-1:0] lat2 [3];
   logic [PIX_W-1:0] tap4 [7];
   logic [PIX_W-1:0] lat4 [7];

   logic [9:0] s2_a, s2_b, s2_sum, s2_out;
   logic [11:0] s4_a, s4_b, s4_c, s4_d, s4_ab, s4_cd, s4_sum;
   logic [11:0] mid3;

   // Centre pair of the seven-tap kernel, weighted by three below
   assign mid3 = {4'b0000, lat4[2]} + {4'b0000, lat4[4]};

   always_ff @(posedge clk)
   begin
      if (!rst_n || clear)
      begin
         for (int i = 0; i < 3; i++)
         begin
            tap2[i] <= '0;
            lat2[i] <= '0;
         end
         for (int i = 0; i < 7; i++)
         begin
            tap4[i] <= '0;
            lat4[i] <= '0;
         end
         s2_a <= '0;
         s2_b <= '0;
         s2_sum <= '0;
         s2_out <= '0;
         s4_a <= '0;
         s4_b <= '0;
         s4_c <= '0;
         s4_d <= '0;
         s4_ab <= '0;
         s4_cd <= '0;
         s4_sum <= '0;
         out_valid <= 1'b0;
         o1 <= '0;
         o2 <= '0;
         o4 <= '0;
      end
      else
      begin
         out_valid <= pix_valid;
         if (pix_valid)
         begin
            tap2[0] <= pix_data;
            tap4[0] <= pix_data;
            for (int i = 1; i < 3; i++)
               tap2[i] <= tap2[i-1];
            for (int i = 1; i < 7; i++)
               tap4[i] <= tap4[i-1];
            lat2 <= tap2;
            lat4 <= tap4;
            o1 <= pix_data;
            o2 <= s2_out[9:2];
            o4 <= s4_sum[11:4];
         end
         // Adder trees run every cycle and settle within the idle gap
         s2_a <= {2'b00, lat2[0]} + {2'b00, lat2[2]};
         s2_b <= {1'b0, lat2[1], 1'b0};
         s2_sum <= s2_a + s2_b;
         s2_out <= s2_sum;
         s4_a <= {4'b0000, lat4[0]} + {4'b0000, lat4[6]};
         s4_b <= {3'b000, lat4[1], 1'b0} + {3'b000, lat4[5], 1'b0};
         s4_c <= mid3 + {mid3[10:0], 1'b0};
         s4_d <= {2'b00, lat4[3], 2'b00};
         s4_ab <= s4_a + s4_b;
         s4_cd <= s4_c + s4_d;
         s4_sum <= s4_ab + s4_cd;
      end
   end

endmodule

`default_nettype wire

/* hdl/hscale_pkg.sv */
`default_nettype none

package hscale_pkg;

   localparam int PIX_W = 8;
   localparam int WORD_W = 32;

   localparam logic [1:0] SCALE_1X = 2'd0;
   localparam logic [1:0] SCALE_2X = 2'd1;
   localparam logic [1:0] SCALE_4X = 2'd2;

   localparam int AXI_ADDR_W = 12;

   // Byte addresses of the host register map
   localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL = 12'h000;
   localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS = 12'h004;
   localparam logic [AXI_ADDR_W-1:0] ADDR_MEM_BASE = 12'h100;

   // Pixel 0 sits in the low byte of the word
   typedef union packed {
      logic [WORD_W-1:0] word;
      logic [3:0][PIX_W-1:0] pix;
   } pix_word_t;

endpackage

`default_nettype wire

/* hdl/hscale_top.sv */
`default_nettype none
`timescale 1ns/1ps

module hscale_top #(
   parameter int MEM_WORDS = 64
) (
   input logic clk,
   input logic rst_n,
   input logic pix_valid,
   input logic [hscale_pkg::PIX_W-1:0] pix_data,
   input logic [hscale_pkg::AXI_ADDR_W-1:0] awaddr,
   input logic awvalid,
   output logic awready,
   input logic [hscale_pkg::WORD_W-1:0] wdata,
   input logic [3:0] wstrb,
   input logic wvalid,
   output logic wready,
   output logic [1:0] bresp,
   output logic bvalid,
   input logic bready,
   input logic [hscale_pkg::AXI_ADDR_W-1:0] araddr,
   input logic arvalid,
   output logic arready,
   output logic [hscale_pkg::WORD_W-1:0] rdata,
   output logic [1:0] rresp,
   output logic rvalid,
   input logic rready
);
   import hscale_pkg::*;

   logic [1:0] scale;
   logic clear;
   logic [$clog2(MEM_WORDS):0] words_written;
   logic f_valid;
   logic [PIX_W-1:0] f_o1, f_o2, f_o4;
   logic ram_we;
   logic [$clog2(MEM_WORDS)-1:0] ram_addr;
   logic [WORD_W-1:0] ram_wdata, ram_rdata;

   mem_port_if #(.MEM_WORDS(MEM_WORDS)) u_pk_port ();
   mem_port_if #(.MEM_WORDS(MEM_WORDS)) u_host_port ();

   hscale_h_filter u_filter (
      .clk(clk), .rst_n(rst_n), .clear(clear),
      .pix_valid(pix_valid), .pix_data(pix_data),
      .out_valid(f_valid), .o1(f_o1), .o2(f_o2), .o4(f_o4)
   );

   pixel_packer #(.MEM_WORDS(MEM_WORDS)) u_packer (
      .clk(clk), .rst_n(rst_n), .scale(scale), .clear(clear),
      .in_valid(f_valid), .o1(f_o1), .o2(f_o2), .o4(f_o4),
      .words_written(words_written), .mem(u_pk_port.requester)
   );

   host_axil_slave #(.MEM_WORDS(MEM_WORDS)) u_host (
      .clk(clk), .rst_n(rst_n),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .words_written(words_written), .scale(scale), .clear(clear),
      .mem(u_host_port.requester)
   );

   // The packer sits on port 0 and wins over the host
   mem_arbiter #(.MEM_WORDS(MEM_WORDS)) u_arbiter (
      .clk(clk), .rst_n(rst_n),
      .p0(u_pk_port.arbiter), .p1(u_host_port.arbiter),
      .ram_we(ram_we), .ram_addr(ram_addr),
      .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
   );

   line_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
      .clk(clk), .we(ram_we), .addr(ram_addr),
      .wdata(ram_wdata), .rdata(ram_rdata)
   );

endmodule

`default_nettype wire

/* hdl/line_ram.sv */
`default_nettype none
`timescale 1ns/1ps

module line_ram #(
   parameter int MEM_WORDS = 64
) (
   input logic clk,
   input logic we,
   input logic [$clog2(MEM_WORDS)-1:0] addr,
   input logic [hscale_pkg::WORD_W-1:0] wdata,
   output logic [hscale_pkg::WORD_W-1:0] rdata
);
   import hscale_pkg::*;

   logic [WORD_W-1:0] mem [MEM_WORDS];

   always_ff @(posedge clk)
   begin
      if (we)
         mem[addr] <= wdata;
      rdata <= mem[addr];
   end

endmodule

`default_nettype wire

/* hdl/mem_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter #(
   parameter int MEM_WORDS = 64
) (
   input logic clk,
   input logic rst_n,
   mem_port_if.arbiter p0,
   mem_port_if.arbiter p1,
   output logic ram_we,
   output logic [$clog2(MEM_WORDS)-1:0] ram_addr,
   output logic [hscale_pkg::WORD_W-1:0] ram_wdata,
   input logic [hscale_pkg::WORD_W-1:0] ram_rdata
);

   // Ports granted in the previous cycle, bit 1 for the host
   logic [1:0] gnt_q;

   // No grant right after a grant, so the requester can drop req first
   assign p0.gnt = p0.req && (gnt_q == 2'b00);
   assign p1.gnt = p1.req && !p0.req && (gnt_q == 2'b00);

   assign ram_we = (p0.gnt && p0.we) || (p1.gnt && p1.we);
   assign ram_addr = p1.gnt ? p1.addr : p0.addr;
   assign ram_wdata = p1.gnt ? p1.wdata : p0.wdata;

   assign p0.rdata = gnt_q[0] ? ram_rdata : '0;
   assign p1.rdata = gnt_q[1] ? ram_rdata : '0;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         gnt_q <= 2'b00;
      else
         gnt_q <= {p1.gnt, p0.gnt};
   end

endmodule

`default_nettype wire

/* hdl/mem_port_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface mem_port_if #(
   parameter int MEM_WORDS = 64
);
   import hscale_pkg::*;

   logic req;
   logic we;
   logic [$clog2(MEM_WORDS)-1:0] addr;
   pix_word_t wdata;
   logic gnt;
   pix_word_t rdata;

   modport requester (output req, we, addr, wdata, input gnt, rdata);
   modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

/* hdl/pixel_packer.sv */
`default_nettype none
`timescale 1ns/1ps

module pixel_packer #(
   parameter int MEM_WORDS = 64
) (
   input logic clk,
   input logic rst_n,
   input logic [1:0] scale,
   input logic clear,
   input logic in_valid,
   input logic [hscale_pkg::PIX_W-1:0] o1,
   input logic [hscale_pkg::PIX_W-1:0] o2,
   input logic [hscale_pkg::PIX_W-1:0] o4,
   output logic [$clog2(MEM_WORDS):0] words_written,
   mem_port_if.requester mem
);
   import hscale_pkg::*;

   localparam int AW = $clog2(MEM_WORDS);

   logic [1:0] phase;
   logic [1:0] lane;
   logic [1:0] keep_mask;
   logic [PIX_W-1:0] sel_pix;
   logic keep;
   pix_word_t acc;

   always_comb
   begin
      case (scale)
         SCALE_2X:
         begin
            keep_mask = 2'd1;
            sel_pix = o2;
         end
         SCALE_4X:
         begin
            keep_mask = 2'd3;
            sel_pix = o4;
         end
         default:
         begin
            keep_mask = 2'd0;
            sel_pix = o1;
         end
      endcase
   end

   // Phase runs modulo 4, which covers all three decimation factors
   assign keep = in_valid && ((phase & keep_mask) == keep_mask)
                 && (words_written != (AW + 1)'(MEM_WORDS));

   assign mem.we = 1'b1;
   assign mem.addr = words_written[AW-1:0];
   assign mem.wdata = acc;

   always_ff @(posedge clk)
   begin
      if (!rst_n || clear)
      begin
         phase <= '0;
         lane <= '0;
         mem.req <= 1'b0;
         words_written <= '0;
      end
      else
      begin
         if (in_valid)
            phase <= phase + 2'd1;
         if (keep)
         begin
            lane <= lane + 2'd1;
            if (lane == 2'd3)
               mem.req <= 1'b1;
         end
         if (mem.gnt)
         begin
            mem.req <= 1'b0;
            words_written <= words_written + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (keep)
         acc.pix[lane] <= sel_pix;
   end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module hscale_tb -o hscale_sim \
   || { echo "Build failed"; exit 1; }
./obj_dir/hscale_sim > sim.log 2>&1
cat sim.log
grep -q "^PASS: all tests$" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

/* verilog.f */
hdl/hscale_pkg.sv
hdl/mem_port_if.sv
hdl/hscale_h_filter.sv
hdl/pixel_packer.sv
hdl/host_axil_slave.sv
hdl/mem_arbiter.sv
hdl/line_ram.sv
hdl/hscale_top.sv
dv/hscale_properties.sv
dv/hscale_tb.sv
